// ==== Makefile ====
SIM      ?= verilator
TOP      ?= tb_soc_xbar
FILELIST ?= sim.f
FLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
BUILD    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD)

// ==== dv/tb_soc_xbar_tests.svh ====
// Directed tests for the SoC crossbar, included in the testbench module
`ifndef TB_SOC_XBAR_TESTS_SVH
`define TB_SOC_XBAR_TESTS_SVH

    // Write pattern, every address bit takes part
    function automatic logic [DATA_WIDTH-1:0] data_for(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F96;
    endfunction

    task automatic expect_hit(input slave_sel_t sel, input logic [ADDR_WIDTH-1:0] addr);
        if (hit_sel.size() != 1) report_error("Slave models did not see exactly one request");
        cmp_sel("slave index", hit_sel.pop_front(), sel);
        cmp_addr("slave address", hit_addr.pop_front(), addr);
    endtask

    task automatic test_interleave();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        logic                  opc;
        for (int i = 0; i < 16; i++) begin           // Eight writes, then eight reads
            addr = L2_INTLV_START + ADDR_WIDTH'(4 * (i % 8));
            do_access(1, i < 8, addr, data_for(addr), rdata, opc);
            // Region start sits on bank 0, so word n goes to bank n
            expect_hit(slave_sel_t'((i % 8) % NR_L2_PORTS), addr);
            cmp_opc("r_opc", opc, 1'b0);
            if (i >= 8) cmp_data("r_rdata", rdata, data_for(addr));
        end
    endtask

    task automatic test_alias();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        logic                  opc;
        addr = PRIV_BANK1_START + 32'h4;
        do_access(1, 1'b1, addr, data_for(addr), rdata, opc);
        expect_hit(slave_sel_t'(NR_L2_PORTS + 1), addr);
        do_access(0, 1'b0, 32'h0000_8004, '0, rdata, opc);  // FC data sees the alias
        expect_hit(slave_sel_t'(NR_L2_PORTS + 1), addr);
        cmp_data("r_rdata", rdata, data_for(addr));
        cmp_opc("r_opc", opc, 1'b0);
        do_access(3, 1'b0, 32'h0000_8004, '0, rdata, opc);  // No alias here
        if (hit_sel.size() != 0) report_error("A slave model saw an unaliased request");
        cmp_opc("r_opc", opc, 1'b1);
        cmp_data("r_rdata", rdata, ERR_RDATA);
    endtask

    task automatic test_contig();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        logic                  opc;
        for (int i = 0; i < 2 * NR_CONTIG_SLAVES; i++) begin
            addr = (i % 3 == 0) ? PRIV_BANK0_START + 32'h100 :
                   (i % 3 == 1) ? PRIV_BANK1_START + 32'h7F0 : BOOT_ROM_END - 32'h3;
            do_access(2, i < 3, addr, data_for(addr), rdata, opc);
            expect_hit(slave_sel_t'(NR_L2_PORTS + i % 3), addr);
            cmp_opc("r_opc", opc, 1'b0);
            if (i >= 3) cmp_data("r_rdata", rdata, data_for(addr));
        end
    endtask

    task automatic test_apb();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  opc;
        logic                  wr;
        for (int i = 0; i < 12; i++) begin           // Last two hit the pslverr address
            addr = (i >= 10) ? APB_ERR_ADDR : PERIPH_START + ADDR_WIDTH'(16 * (i % 5));
            wr   = (i < 5) || (i == 10);
            do_access(4, wr, addr, data_for(addr), rdata, opc);
            expect_hit(APB_SEL, addr);
            cmp_addr("paddr", apb_addr_log.pop_front(), addr);
            cmp_opc("pwrite", apb_write_log.pop_front(), wr);
            wdata = apb_wdata_log.pop_front();
            if (wr) begin
                cmp_data("pwdata", wdata, data_for(addr));
                cmp_data("r_rdata", rdata, '0);      // Writes return zero
            end else begin
                cmp_data("r_rdata", rdata, data_for(addr));
            end
            cmp_opc("r_opc", opc, addr == APB_ERR_ADDR);
        end
    endtask

    // Four back to back bank 0 accesses, req stays high until the last gnt
    task automatic stream_bank0(input int m, input logic wr);
        logic [ADDR_WIDTH-1:0] addr;
        int sent;
        int rcvd;
        int cyc;
        int first;
        sent  = 0;
        rcvd  = 0;
        cyc   = 0;
        first = (m == 1) ? 0 : 4;                    // Own set of bank 0 words
        addr  = L2_INTLV_START + ADDR_WIDTH'(16 * first);
        master_req[m] <= '{req: 1'b1, wen: ~wr, add: addr, wdata: data_for(addr), be: '1};
        while (rcvd < 4) begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT) report_error("Timeout in bank 0 stream");
            if (master_rsp[m].r_valid) begin         // Responses in request order
                addr = L2_INTLV_START + ADDR_WIDTH'(16 * (first + rcvd));
                if (!wr) cmp_data("r_rdata", master_rsp[m].r_rdata, data_for(addr));
                rcvd++;
            end
            if (master_req[m].req && master_rsp[m].gnt) begin
                grant_order.push_back(m);
                sent++;
                addr = L2_INTLV_START + ADDR_WIDTH'(16 * (first + sent));
                master_req[m].add   <= addr;
                master_req[m].wdata <= data_for(addr);
                if (sent == 4) master_req[m].req <= 1'b0;
            end
        end
    endtask

    task automatic test_arbitration();
        for (int pass = 0; pass < 2; pass++) begin   // Writes, then reads
            grant_order.delete();
            fork
                stream_bank0(1, pass == 0);
                stream_bank0(2, pass == 0);
            join
            if (grant_order.size() != 8) report_error("Bank 0 did not grant eight requests");
            for (int i = 1; i < 8; i++) begin
                if (grant_order[i] == grant_order[i-1]) begin
                    report_error("Bank 0 grants did not alternate");
                end
            end
            hit_sel.delete();
            hit_addr.delete();
        end
    endtask

    task automatic test_error();
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rdata;
        logic                  opc;
        for (int m = 0; m < NR_MASTERS; m++) begin
            for (int k = 0; k < 2; k++) begin        // Write far out, read in the map gap
                addr = (k == 0) ? 32'h3000_0000 + ADDR_WIDTH'(4 * m) : BOOT_ROM_END + 32'h1;
                do_access(m, k == 0, addr, data_for(addr), rdata, opc);
                if (hit_sel.size() != 0) report_error("A slave model saw an unmapped request");
                cmp_opc("r_opc", opc, 1'b1);
                cmp_data("r_rdata", rdata, ERR_RDATA);
            end
        end
    endtask

`endif

// ==== dv/tb_soc_xbar.sv ====
// Testbench for the SoC crossbar with TCDM memory models, an APB slave model and directed tests
module tb_soc_xbar;
    timeunit 1ns;
    timeprecision 1ps;
    import soc_xbar_pkg::*;

    localparam int NR_MASTERS  = 5;
    localparam int NR_L2_PORTS = 4;
    localparam int NR_MEMS     = NR_L2_PORTS + NR_CONTIG_SLAVES;   // Memory models
    localparam int TIMEOUT     = 64;                               // Cycles per wait
    localparam slave_sel_t APB_SEL = slave_sel_t'(NR_MEMS);
    localparam logic [ADDR_WIDTH-1:0] APB_ERR_ADDR = 32'h1A2F_FFFC; // Model answers pslverr

    logic      clk;
    logic      rst_n = 1'b0;
    tcdm_req_t master_req [NR_MASTERS];
    tcdm_rsp_t master_rsp [NR_MASTERS];
    tcdm_req_t l2_req     [NR_L2_PORTS];
    tcdm_rsp_t l2_rsp     [NR_L2_PORTS];
    tcdm_req_t contig_req [NR_CONTIG_SLAVES];
    tcdm_rsp_t contig_rsp [NR_CONTIG_SLAVES];
    tcdm_req_t mem_req    [NR_MEMS];        // L2 banks, then contig slaves
    tcdm_rsp_t mem_rsp    [NR_MEMS];
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp = '0;

    logic [DATA_WIDTH-1:0]              mem [NR_MEMS][4096];
    logic [NR_MEMS-1:0]                 mem_rvalid = '0;
    logic [NR_MEMS-1:0][DATA_WIDTH-1:0] mem_rdata  = '0;
    logic [DATA_WIDTH-1:0] apb_mem [256];
    logic [1:0]            apb_wait;        // Wait states left
    logic                  apb_busy;        // Transfer still open from last cycle
    logic [ADDR_WIDTH-1:0] apb_setup_addr;
    logic [31:0]           lcg_state = 32'h45c908bd;
    slave_sel_t            hit_sel  [$];    // Every request seen by any slave model
    logic [ADDR_WIDTH-1:0] hit_addr [$];
    logic [ADDR_WIDTH-1:0] apb_addr_log  [$];  // Completed APB transfers
    logic [DATA_WIDTH-1:0] apb_wdata_log [$];
    logic                  apb_write_log [$];
    int                    grant_order   [$];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    soc_xbar_top #(
        .NR_MASTERS  (NR_MASTERS),
        .NR_L2_PORTS (NR_L2_PORTS)
    ) u_soc_xbar_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .master_req_i (master_req),
        .master_rsp_o (master_rsp),
        .l2_req_o     (l2_req),
        .l2_rsp_i     (l2_rsp),
        .contig_req_o (contig_req),
        .contig_rsp_i (contig_rsp),
        .apb_req_o    (apb_req),
        .apb_rsp_i    (apb_rsp)
    );

    ////////////////////////////////////////////////////////////
    // TCDM memory models
    ////////////////////////////////////////////////////////////
    for (genvar s = 0; s < NR_MEMS; s++) begin : g_mem
        assign mem_rsp[s] = '{gnt: 1'b1, r_valid: mem_rvalid[s], r_opc: 1'b0,
                              r_rdata: mem_rdata[s]};   // Grant at once
    end
    for (genvar b = 0; b < NR_L2_PORTS; b++) begin : g_l2
        assign mem_req[b] = l2_req[b];
        assign l2_rsp[b]  = mem_rsp[b];
    end
    for (genvar c = 0; c < NR_CONTIG_SLAVES; c++) begin : g_contig
        assign mem_req[NR_L2_PORTS + c] = contig_req[c];
        assign contig_rsp[c]            = mem_rsp[NR_L2_PORTS + c];
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rvalid <= '0;
        end else begin
            for (int s = 0; s < NR_MEMS; s++) begin
                mem_rvalid[s] <= mem_req[s].req;             // Response one cycle later
                if (mem_req[s].req) begin
                    if (mem_req[s].be !== '1) begin          // Masters only send full words
                        report_error("A memory saw byte enables other than a full word");
                    end
                    hit_sel.push_back(slave_sel_t'(s));
                    hit_addr.push_back(mem_req[s].add);
                    if (!mem_req[s].wen) begin               // Full words only
                        mem[s][mem_req[s].add[13:2]] <= mem_req[s].wdata;
                    end
                    mem_rdata[s] <= mem[s][mem_req[s].add[13:2]];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // APB slave model
    ////////////////////////////////////////////////////////////
    function automatic logic [1:0] next_wait_states();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[17:16];                            // Upper bits, 0 to 3
    endfunction

    always @(posedge clk or negedge rst_n) begin : apb_model
        logic [1:0] waits;
        if (!rst_n) begin
            apb_rsp  <= '0;
            apb_busy <= 1'b0;
        end else begin
            apb_busy <= apb_req.psel && !(apb_req.penable && apb_rsp.pready);
            if (apb_req.psel && !apb_req.penable) begin           // Setup phase
                if (apb_busy) report_error("APB setup phase lasted more than one cycle");
                hit_sel.push_back(APB_SEL);
                hit_addr.push_back(apb_req.paddr);
                waits = next_wait_states();
                apb_wait        <= waits;
                apb_setup_addr  <= apb_req.paddr;
                apb_rsp.pready  <= (waits == 2'd0);
                apb_rsp.pslverr <= (apb_req.paddr == APB_ERR_ADDR);
                apb_rsp.prdata  <= apb_mem[apb_req.paddr[9:2]];
            end else if (apb_req.psel && apb_req.penable) begin   // Access phase
                if (!apb_busy) report_error("APB access phase came without a setup phase");
                if (apb_rsp.pready) begin                         // Transfer ends here
                    cmp_addr("paddr", apb_req.paddr, apb_setup_addr);
                    apb_rsp.pready <= 1'b0;
                    apb_addr_log.push_back(apb_req.paddr);
                    apb_wdata_log.push_back(apb_req.pwdata);
                    apb_write_log.push_back(apb_req.pwrite);
                    if (apb_req.pwrite) apb_mem[apb_req.paddr[9:2]] <= apb_req.pwdata;
                end else begin
                    apb_wait       <= apb_wait - 1'b1;
                    apb_rsp.pready <= (apb_wait == 2'd1);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Error reporting and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        end_with_failure();
    endtask

    task automatic cmp_data(input string name, input logic [DATA_WIDTH-1:0] act, exp);
        if (act !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic cmp_addr(input string name, input logic [ADDR_WIDTH-1:0] act, exp);
        if (act !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic cmp_opc(input string name, input logic act, exp);
        if (act !== exp) begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    task automatic cmp_sel(input string name, input slave_sel_t act, exp);
        if (act !== exp) begin
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, name, act, exp);
            end_with_failure();
        end
    endtask

    // One blocking access, request held until gnt
    task automatic do_access(input int m, input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] wdata,
                             output logic [DATA_WIDTH-1:0] rdata, output logic opc);
        int cyc;
        master_req[m] <= '{req: 1'b1, wen: ~wr, add: addr, wdata: wdata, be: '1};
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT) report_error("Timeout waiting for gnt");
        end while (!master_rsp[m].gnt);
        master_req[m].req <= 1'b0;
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
            if (cyc > TIMEOUT) report_error("Timeout waiting for r_valid");
        end while (!master_rsp[m].r_valid);
        rdata = master_rsp[m].r_rdata;
        opc   = master_rsp[m].r_opc;
    endtask

    `include "tb_soc_xbar_tests.svh"

    initial begin
        rst_n = 1'b0;
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_req[m] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_interleave();
        test_alias();
        test_contig();
        test_apb();
        test_arbitration();
        test_error();
        $display("TEST PASS");
        $finish;
    end

endmodule : tb_soc_xbar

// ==== sim.f ====
+incdir+dv
verilog/soc_xbar_pkg.sv
verilog/tcdm_addr_decoder.sv
verilog/rr_arbiter.sv
verilog/tcdm_xbar.sv
verilog/tcdm_apb_bridge.sv
verilog/soc_xbar_top.sv
dv/tb_soc_xbar.sv

// ==== verilog/rr_arbiter.sv ====
// Round-robin arbiter with a rotating priority pointer and a combinational one-hot grant
module rr_arbiter #(
    parameter int NR_MASTERS = 5
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [NR_MASTERS-1:0] req_i,
    output logic [NR_MASTERS-1:0] gnt_o,  // One-hot
    input  logic                  take_i  // Grant consumed by the slave
);

    localparam int IDX_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    logic [IDX_W-1:0] ptr_q;   // Highest priority requester
    logic [IDX_W-1:0] win_idx; // Current winner

    // Search starts at the pointer and wraps around
    always_comb begin
        int unsigned idx;
        logic        found;
        gnt_o   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < NR_MASTERS; i++) begin
            idx = (int'(ptr_q) + i) % NR_MASTERS;
            if (!found && req_i[idx]) begin
                found      = 1'b1;
                gnt_o[idx] = 1'b1;
                win_idx    = IDX_W'(idx);
            end
        end
    end

    // Winner drops to lowest priority once served
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (take_i) begin
            if (int'(win_idx) == NR_MASTERS - 1) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

endmodule : rr_arbiter

// ==== verilog/soc_xbar_pkg.sv ====
// SoC crossbar package with bus widths, memory map and the TCDM and APB bus structs
package soc_xbar_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8; // One enable per byte lane

    ////////////////////////////////////////////////////////////
    // Memory map
    ////////////////////////////////////////////////////////////
    // Private banks sit back to back below the interleaved region
    localparam logic [ADDR_WIDTH-1:0] PRIV_BANK0_START = 32'h1C00_0000;
    localparam logic [ADDR_WIDTH-1:0] PRIV_BANK0_END   = 32'h1C00_7FFF;
    localparam logic [ADDR_WIDTH-1:0] PRIV_BANK1_START = 32'h1C00_8000;
    localparam logic [ADDR_WIDTH-1:0] PRIV_BANK1_END   = 32'h1C00_FFFF;

    localparam logic [ADDR_WIDTH-1:0] BOOT_ROM_START   = 32'h1A00_0000;
    localparam logic [ADDR_WIDTH-1:0] BOOT_ROM_END     = 32'h1A00_1FFF;

    // Word interleaved L2, 512 KiB
    localparam logic [ADDR_WIDTH-1:0] L2_INTLV_START   = 32'h1C01_0000;
    localparam logic [ADDR_WIDTH-1:0] L2_INTLV_END     = 32'h1C08_FFFF;

    localparam logic [ADDR_WIDTH-1:0] PERIPH_START     = 32'h1A10_0000; // APB peripherals
    localparam logic [ADDR_WIDTH-1:0] PERIPH_END       = 32'h1A2F_FFFF;

    // Legacy FC data alias, top 12 address bits
    localparam logic [11:0] ALIAS_FROM_PREFIX = 12'h000;
    localparam logic [11:0] ALIAS_TO_PREFIX   = 12'h1C0;

    // Read data returned for unmapped accesses
    localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hBADA_CCE5;

    localparam int NR_CONTIG_SLAVES = 3; // Private bank 0, private bank 1, boot rom

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////
    // Flat slave index
    // L2 banks first, then contig slaves, APB bridge and error slave
    typedef logic [3:0] slave_sel_t;

    typedef struct packed {
        logic                  req;
        logic                  wen;   // Low for write
        logic [ADDR_WIDTH-1:0] add;   // Byte address
        logic [DATA_WIDTH-1:0] wdata;
        logic [BE_WIDTH-1:0]   be;
    } tcdm_req_t;

    typedef struct packed {
        logic                  gnt;     // Same cycle as req
        logic                  r_valid; // One per accepted request
        logic                  r_opc;   // Set on error response
        logic [DATA_WIDTH-1:0] r_rdata;
    } tcdm_rsp_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [ADDR_WIDTH-1:0] paddr;
        logic [DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                  pready;
        logic                  pslverr;
        logic [DATA_WIDTH-1:0] prdata;
    } apb_rsp_t;

endpackage : soc_xbar_pkg

// ==== verilog/soc_xbar_top.sv ====
// SoC memory interconnect top that wires the address decoders, the crossbar and the APB bridge
module soc_xbar_top #(
    parameter int NR_MASTERS  = 5, // FC data, FC instr, uDMA TX, uDMA RX, debug
    parameter int NR_L2_PORTS = 4  // Interleaved banks, power of two
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Master side
    input  soc_xbar_pkg::tcdm_req_t master_req_i [NR_MASTERS],
    output soc_xbar_pkg::tcdm_rsp_t master_rsp_o [NR_MASTERS],
    // Interleaved L2 banks
    output soc_xbar_pkg::tcdm_req_t l2_req_o     [NR_L2_PORTS],
    input  soc_xbar_pkg::tcdm_rsp_t l2_rsp_i     [NR_L2_PORTS],
    // Private bank 0, private bank 1, boot rom
    output soc_xbar_pkg::tcdm_req_t contig_req_o [soc_xbar_pkg::NR_CONTIG_SLAVES],
    input  soc_xbar_pkg::tcdm_rsp_t contig_rsp_i [soc_xbar_pkg::NR_CONTIG_SLAVES],
    // Peripheral bus
    output soc_xbar_pkg::apb_req_t  apb_req_o,
    input  soc_xbar_pkg::apb_rsp_t  apb_rsp_i
);
    import soc_xbar_pkg::*;

    localparam int NR_SLAVES = NR_L2_PORTS + 5;                  // Banks, 3 contig, APB, error
    localparam int APB_IDX   = NR_L2_PORTS + NR_CONTIG_SLAVES;

    tcdm_req_t  dec_req [NR_MASTERS];   // Requests after alias
    slave_sel_t dec_sel [NR_MASTERS];
    tcdm_req_t  slv_req [NR_SLAVES-1];  // External slave ports
    tcdm_rsp_t  slv_rsp [NR_SLAVES-1];

    ////////////////////////////////////////////////////////////
    // Address decode per master
    ////////////////////////////////////////////////////////////
    for (genvar m = 0; m < NR_MASTERS; m++) begin : g_dec
        tcdm_addr_decoder #(
            .NR_L2_PORTS (NR_L2_PORTS),
            .ALIAS_EN    (m == 0)       // Legacy alias on FC data only
        ) u_dec (
            .req_i (master_req_i[m]),
            .req_o (dec_req[m]),
            .sel_o (dec_sel[m])
        );
    end

    tcdm_xbar #(
        .NR_MASTERS (NR_MASTERS),
        .NR_SLAVES  (NR_SLAVES)
    ) u_xbar (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .mst_req_i (dec_req),
        .mst_sel_i (dec_sel),
        .mst_rsp_o (master_rsp_o),
        .slv_req_o (slv_req),
        .slv_rsp_i (slv_rsp)
    );

    // Split the flat slave list onto the ports
    for (genvar b = 0; b < NR_L2_PORTS; b++) begin : g_l2
        assign l2_req_o[b] = slv_req[b];
        assign slv_rsp[b]  = l2_rsp_i[b];
    end

    for (genvar c = 0; c < NR_CONTIG_SLAVES; c++) begin : g_contig
        assign contig_req_o[c]          = slv_req[NR_L2_PORTS + c];
        assign slv_rsp[NR_L2_PORTS + c] = contig_rsp_i[c];
    end

    tcdm_apb_bridge u_apb_bridge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (slv_req[APB_IDX]),
        .rsp_o     (slv_rsp[APB_IDX]),
        .apb_req_o (apb_req_o),
        .apb_rsp_i (apb_rsp_i)
    );

endmodule : soc_xbar_top

// ==== verilog/tcdm_addr_decoder.sv ====
// TCDM address decoder that applies the legacy alias and maps an address to a slave index
module tcdm_addr_decoder #(
    parameter int NR_L2_PORTS = 4,    // Power of two
    parameter bit ALIAS_EN    = 1'b0  // Only on the FC data port
) (
    input  soc_xbar_pkg::tcdm_req_t  req_i,
    output soc_xbar_pkg::tcdm_req_t  req_o,
    output soc_xbar_pkg::slave_sel_t sel_o
);
    import soc_xbar_pkg::*;

    localparam int OFFS_BITS = $clog2(BE_WIDTH);   // Byte offset inside a word
    localparam int PFX_BITS  = $bits(ALIAS_FROM_PREFIX);

    // Slave indices after the L2 banks
    localparam slave_sel_t SEL_PRIV0 = slave_sel_t'(NR_L2_PORTS);
    localparam slave_sel_t SEL_PRIV1 = slave_sel_t'(NR_L2_PORTS + 1);
    localparam slave_sel_t SEL_ROM   = slave_sel_t'(NR_L2_PORTS + 2);
    localparam slave_sel_t SEL_APB   = slave_sel_t'(NR_L2_PORTS + NR_CONTIG_SLAVES);
    localparam slave_sel_t SEL_ERR   = slave_sel_t'(NR_L2_PORTS + NR_CONTIG_SLAVES + 1);

    logic [ADDR_WIDTH-1:0] addr;     // Address after alias
    logic [ADDR_WIDTH-1:0] word_idx; // Word number, low bits pick the bank

    ////////////////////////////////////////////////////////////
    // Legacy alias
    ////////////////////////////////////////////////////////////
    always_comb begin
        addr = req_i.add;
        // 0x000xxxxx is remapped to 0x1C0xxxxx
        if (ALIAS_EN && (addr[ADDR_WIDTH-1 -: PFX_BITS] == ALIAS_FROM_PREFIX)) begin
            addr[ADDR_WIDTH-1 -: PFX_BITS] = ALIAS_TO_PREFIX;
        end
    end

    always_comb begin
        req_o     = req_i;
        req_o.add = addr; // Only the address changes
    end

    assign word_idx = addr >> OFFS_BITS;

    ////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        if ((addr >= L2_INTLV_START) && (addr <= L2_INTLV_END)) begin
            sel_o = slave_sel_t'(word_idx % NR_L2_PORTS); // Bank from word bits
        end else if ((addr >= PRIV_BANK0_START) && (addr <= PRIV_BANK0_END)) begin
            sel_o = SEL_PRIV0;
        end else if ((addr >= PRIV_BANK1_START) && (addr <= PRIV_BANK1_END)) begin
            sel_o = SEL_PRIV1;
        end else if ((addr >= BOOT_ROM_START) && (addr <= BOOT_ROM_END)) begin
            sel_o = SEL_ROM;
        end else if ((addr >= PERIPH_START) && (addr <= PERIPH_END)) begin
            sel_o = SEL_APB;                          // Peripherals via bridge
        end else begin
            sel_o = SEL_ERR;                          // Unmapped
        end
    end

endmodule : tcdm_addr_decoder

// ==== verilog/tcdm_apb_bridge.sv ====
// TCDM to APB3 bridge with one outstanding transfer and an idle, setup and access FSM
module tcdm_apb_bridge (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  soc_xbar_pkg::tcdm_req_t req_i,
    output soc_xbar_pkg::tcdm_rsp_t rsp_o,
    output soc_xbar_pkg::apb_req_t  apb_req_o,
    input  soc_xbar_pkg::apb_rsp_t  apb_rsp_i
);
    import soc_xbar_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,  // psel only
        ST_ACCESS  // psel and penable until pready
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic                  accept;   // TCDM handshake
    logic                  done;     // APB transfer completes
    logic [ADDR_WIDTH-1:0] paddr_q;
    logic [DATA_WIDTH-1:0] pwdata_q;
    logic                  pwrite_q;
    logic                  rvalid_q;
    logic                  ropc_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    assign accept = req_i.req && (state_q == ST_IDLE);
    assign done   = (state_q == ST_ACCESS) && apb_rsp_i.pready;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) state_d = ST_SETUP;
            end
            ST_SETUP:  state_d = ST_ACCESS;          // Always one setup cycle
            ST_ACCESS: begin
                if (apb_rsp_i.pready) state_d = ST_IDLE;
            end
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            rvalid_q <= done; // Response the cycle after pready
        end
    end

    // Transfer and response payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            paddr_q  <= req_i.add;
            pwdata_q <= req_i.wdata;
            pwrite_q <= ~req_i.wen;   // wen is active low
        end
        if (done) begin
            rdata_q <= pwrite_q ? '0 : apb_rsp_i.prdata; // Writes return zero
            ropc_q  <= apb_rsp_i.pslverr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////
    always_comb begin
        apb_req_o.psel    = (state_q != ST_IDLE);
        apb_req_o.penable = (state_q == ST_ACCESS);
        apb_req_o.pwrite  = pwrite_q;
        apb_req_o.paddr   = paddr_q;
        apb_req_o.pwdata  = pwdata_q;

        rsp_o.gnt     = accept;
        rsp_o.r_valid = rvalid_q;
        rsp_o.r_opc   = ropc_q;
        rsp_o.r_rdata = rdata_q;
    end

endmodule : tcdm_apb_bridge

// ==== verilog/tcdm_xbar.sv ====
// TCDM crossbar with per-slave round-robin arbitration, response routing and an error slave
module tcdm_xbar #(
    parameter int NR_MASTERS = 5,
    parameter int NR_SLAVES  = 9  // Last index is the internal error slave
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  soc_xbar_pkg::tcdm_req_t  mst_req_i [NR_MASTERS],
    input  soc_xbar_pkg::slave_sel_t mst_sel_i [NR_MASTERS],
    output soc_xbar_pkg::tcdm_rsp_t  mst_rsp_o [NR_MASTERS],
    output soc_xbar_pkg::tcdm_req_t  slv_req_o [NR_SLAVES-1],
    input  soc_xbar_pkg::tcdm_rsp_t  slv_rsp_i [NR_SLAVES-1]
);
    import soc_xbar_pkg::*;

    localparam int MST_W   = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;
    localparam int ERR_IDX = NR_SLAVES - 1;

    logic [NR_MASTERS-1:0] arb_req [NR_SLAVES]; // Masters aiming at each slave
    logic [NR_MASTERS-1:0] arb_gnt [NR_SLAVES]; // Arbiter winner, one-hot
    logic [MST_W-1:0]      win_idx [NR_SLAVES];
    logic [MST_W-1:0]      owner_q [NR_SLAVES]; // Master owed the next response
    tcdm_req_t             slv_req [NR_SLAVES];
    tcdm_rsp_t             slv_rsp [NR_SLAVES];
    logic [NR_SLAVES-1:0]  slv_take;            // Request accepted by slave
    logic                  err_valid_q;

    ////////////////////////////////////////////////////////////
    // Request path, one arbiter per slave
    ////////////////////////////////////////////////////////////
    for (genvar s = 0; s < NR_SLAVES; s++) begin : g_slv

        always_comb begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                arb_req[s][m] = mst_req_i[m].req && (int'(mst_sel_i[m]) == s);
            end
        end

        rr_arbiter #(
            .NR_MASTERS (NR_MASTERS)
        ) u_arb (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (arb_req[s]),
            .gnt_o   (arb_gnt[s]),
            .take_i  (slv_take[s])
        );

        // Forward the winning master's request
        always_comb begin
            slv_req[s] = '0;
            win_idx[s] = '0;
            for (int m = 0; m < NR_MASTERS; m++) begin
                if (arb_gnt[s][m]) begin
                    slv_req[s] = mst_req_i[m];
                    win_idx[s] = MST_W'(m);
                end
            end
        end

        assign slv_take[s] = slv_req[s].req & slv_rsp[s].gnt;

        // Remember who gets the response
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                owner_q[s] <= '0;
            end else if (slv_take[s]) begin
                owner_q[s] <= win_idx[s];
            end
        end

        if (s < ERR_IDX) begin : g_ext
            assign slv_req_o[s] = slv_req[s]; // External slave port
            assign slv_rsp[s]   = slv_rsp_i[s];
        end
    end

    ////////////////////////////////////////////////////////////
    // Error slave
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= slv_take[ERR_IDX]; // Answer one cycle after grant
        end
    end

    always_comb begin
        slv_rsp[ERR_IDX].gnt     = 1'b1;        // Never stalls
        slv_rsp[ERR_IDX].r_valid = err_valid_q;
        slv_rsp[ERR_IDX].r_opc   = err_valid_q;
        slv_rsp[ERR_IDX].r_rdata = ERR_RDATA;
    end

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////
    // gnt follows the current arbitration, r_* follow the owner register
    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            mst_rsp_o[m] = '0;
            for (int s = 0; s < NR_SLAVES; s++) begin
                if (arb_gnt[s][m]) begin
                    mst_rsp_o[m].gnt = slv_rsp[s].gnt;
                end
                if (slv_rsp[s].r_valid && (owner_q[s] == MST_W'(m))) begin
                    mst_rsp_o[m].r_valid = 1'b1;
                    mst_rsp_o[m].r_opc   = slv_rsp[s].r_opc;
                    mst_rsp_o[m].r_rdata = slv_rsp[s].r_rdata;
                end
            end
        end
    end

endmodule : tcdm_xbar
